// ==== design/loader_pkg.sv ====
// Shared widths, timing constants and memory state encoding
// The memory holds 2**MEM_AW beats of BEAT_W bits and wraps beyond that
// READ_LAT must be 2 or more, REFRESH_PERIOD a power of two
package loader_pkg;

    // Host byte address from the ioctl port
    localparam int IOCTL_AW = 26;

    // Beat geometry
    localparam int BEAT_W     = 64;
    localparam int BEAT_BYTES = BEAT_W / 8;
    localparam int LANE_W     = 3;

    // Beat address and burst length
    localparam int MEM_AW    = 8;
    localparam int MEM_DEPTH = 2 ** MEM_AW;
    localparam int BURST_W   = 5;

    // Memory timing
    localparam int READ_LAT       = 4;
    localparam int REFRESH_PERIOD = 16;

    // Counter widths derived from the timing above
    localparam int LAT_W  = $clog2(READ_LAT);
    localparam int RFSH_W = $clog2(REFRESH_PERIOD);

    // Wait count loaded on read acceptance so that the first beat lands
    // READ_LAT cycles after the accepting edge
    localparam logic [LAT_W-1:0]  LAT_LOAD = LAT_W'(READ_LAT - 2);
    localparam logic [RFSH_W-1:0] RFSH_MAX = RFSH_W'(REFRESH_PERIOD - 1);

    typedef enum logic [2:0] {
        IDLE,
        REFRESH,
        WRITE,
        READ_WAIT,
        READ_BURST
    } mem_state_t;

endpackage

// ==== design/mem_req_if.sv ====
// Command channel from the request stage into the burst memory
// A command stays steady while rd or wr is high and is taken on a
// rising edge where busy is low. Writes are always a single beat
interface mem_req_if;

    // Command strobes that are never both high
    logic                                rd;
    logic                                wr;

    // Beat address and beat count for reads
    logic [loader_pkg::MEM_AW-1:0]       addr;
    logic [loader_pkg::BURST_W-1:0]      burstcnt;

    // Write payload with one enable per byte lane
    logic [loader_pkg::BEAT_W-1:0]       din;
    logic [loader_pkg::BEAT_BYTES-1:0]   be;

    // Memory cannot take a command this cycle
    logic                                busy;

    modport host (
        output rd, wr, addr, burstcnt, din, be,
        input  busy
    );

    modport mem (
        input  rd, wr, addr, burstcnt, din, be,
        output busy
    );

endinterface

// ==== design/mem_request_stage.sv ====
// Turns ioctl byte writes and readback requests into memory commands
// A byte is written as one beat with the byte in every lane and a one-hot
// enable. Address bits above LANE_W+MEM_AW are ignored
// rd_len is the beat count minus one and must stay below 16
// A write is not taken while a read is in flight, and the other way round
module mem_request_stage (
    input  logic                              clk,
    input  logic                              reset,

    // ROM download
    input  logic                              downloading,
    input  logic [loader_pkg::IOCTL_AW-1:0]   ioctl_addr,
    input  logic [7:0]                        ioctl_dout,
    input  logic                              ioctl_wr,
    output logic                              dwnld_busy,

    // Readback request
    input  logic                              rd_req,
    input  logic [loader_pkg::MEM_AW-1:0]     rd_addr,
    input  logic [loader_pkg::BURST_W-1:0]    rd_len,
    output logic                              rd_busy,
    input  logic                              burst_done,

    mem_req_if.host                           req
);

    logic take_wr;
    logic take_rd;
    logic accepted;

    assign take_wr  = downloading && ioctl_wr && !dwnld_busy && !rd_busy;
    assign take_rd  = rd_req && !downloading && !rd_busy && !dwnld_busy;

    // Same acceptance rule the memory applies
    assign accepted = (req.rd || req.wr) && !req.busy;

    // Strobes and busy levels
    always_ff @(posedge clk) begin
        if (reset) begin
            req.wr     <= 1'b0;
            req.rd     <= 1'b0;
            dwnld_busy <= 1'b0;
            rd_busy    <= 1'b0;
        end else begin
            if (accepted) begin
                req.wr <= 1'b0;
                req.rd <= 1'b0;
            end
            // Download side frees up as soon as the beat is taken
            if (accepted && req.wr) begin
                dwnld_busy <= 1'b0;
            end
            // Read side waits for the final beat
            if (burst_done) begin
                rd_busy <= 1'b0;
            end
            if (take_wr) begin
                req.wr     <= 1'b1;
                dwnld_busy <= 1'b1;
            end
            if (take_rd) begin
                req.rd  <= 1'b1;
                rd_busy <= 1'b1;
            end
        end
    end

    // Command payload loaded only when a new command is taken
    always_ff @(posedge clk) begin
        if (take_wr) begin
            req.addr     <= ioctl_addr[loader_pkg::LANE_W +: loader_pkg::MEM_AW];
            req.burstcnt <= {{(loader_pkg::BURST_W-1){1'b0}}, 1'b1};
            req.din      <= {loader_pkg::BEAT_BYTES{ioctl_dout}};
            req.be       <= {{(loader_pkg::BEAT_BYTES-1){1'b0}}, 1'b1}
                            << ioctl_addr[loader_pkg::LANE_W-1:0];
        end else if (take_rd) begin
            req.addr     <= rd_addr;
            req.burstcnt <= rd_len + 1'b1;
            req.be       <= '0;
        end
    end

    // Reads and writes share one payload, so they must never overlap
    a_one_cmd: assert property (@(posedge clk) disable iff (reset)
        !(req.wr && req.rd));

endmodule

// ==== design/burst_memory.sv ====
// Beat-wide memory model with refresh slots and fixed-latency bursts
// Contents start at zero; this is a simulation model of the DDR behind
// the loader. A refresh costs one busy cycle after REFRESH_PERIOD idle
// cycles and is held off while a command is running
// burstcnt must be at least one on reads and is ignored on writes
module burst_memory (
    input  logic                            clk,
    input  logic                            reset,

    mem_req_if.mem                          req,

    output logic [loader_pkg::BEAT_W-1:0]   dout,
    output logic                            dout_ready
);

    logic [loader_pkg::BEAT_W-1:0]   mem [0:loader_pkg::MEM_DEPTH-1];

    loader_pkg::mem_state_t          state;
    logic [loader_pkg::RFSH_W-1:0]   rfsh_cnt;
    logic [loader_pkg::LAT_W-1:0]    lat_cnt;
    logic [loader_pkg::BURST_W-1:0]  beat_cnt;
    logic [loader_pkg::MEM_AW-1:0]   areg;
    logic                            accept;

    initial begin
        for (int i = 0; i < loader_pkg::MEM_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // Busy also covers the last beat, which leaves after the FSM is idle
    assign req.busy = (state != loader_pkg::IDLE) || dout_ready;
    assign accept   = (req.rd || req.wr) && !req.busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= loader_pkg::IDLE;
            rfsh_cnt   <= '0;
            lat_cnt    <= '0;
            beat_cnt   <= '0;
            dout_ready <= 1'b0;
        end else begin
            dout_ready <= (state == loader_pkg::READ_BURST);
            case (state)
                loader_pkg::IDLE: begin
                    // Idle time counter saturates until the slot is taken
                    if (rfsh_cnt != loader_pkg::RFSH_MAX) begin
                        rfsh_cnt <= rfsh_cnt + 1'b1;
                    end
                    if (accept && req.wr) begin
                        state <= loader_pkg::WRITE;
                    end else if (accept) begin
                        state    <= loader_pkg::READ_WAIT;
                        lat_cnt  <= loader_pkg::LAT_LOAD;
                        beat_cnt <= req.burstcnt;
                    end else if (rfsh_cnt == loader_pkg::RFSH_MAX) begin
                        state <= loader_pkg::REFRESH;
                    end
                end
                loader_pkg::REFRESH: begin
                    rfsh_cnt <= '0;
                    state    <= loader_pkg::IDLE;
                end
                loader_pkg::WRITE: begin
                    state <= loader_pkg::IDLE;
                end
                loader_pkg::READ_WAIT: begin
                    if (lat_cnt == '0) begin
                        state <= loader_pkg::READ_BURST;
                    end else begin
                        lat_cnt <= lat_cnt - 1'b1;
                    end
                end
                loader_pkg::READ_BURST: begin
                    beat_cnt <= beat_cnt - 1'b1;
                    if (beat_cnt == 1) begin
                        state <= loader_pkg::IDLE;
                    end
                end
                default: begin
                    state <= loader_pkg::IDLE;
                end
            endcase
        end
    end

    // Array and read data path
    always_ff @(posedge clk) begin
        // Write lands on the accepting edge and WRITE only holds busy
        if (accept && req.wr) begin
            for (int i = 0; i < loader_pkg::BEAT_BYTES; i++) begin
                if (req.be[i]) begin
                    mem[req.addr][8*i +: 8] <= req.din[8*i +: 8];
                end
            end
        end
        if (accept) begin
            areg <= req.addr;
        end else if (state == loader_pkg::READ_BURST) begin
            // Wraps within MEM_AW bits
            areg <= areg + 1'b1;
        end
        if (state == loader_pkg::READ_BURST) begin
            dout <= mem[areg];
        end
    end

    // A waiting command must not change under the memory
    a_cmd_stable: assert property (@(posedge clk) disable iff (reset)
        (req.rd || req.wr) && req.busy |=>
            $stable(req.addr) && $stable(req.din) && $stable(req.be));

    // The host may only drop a command that met a cycle with busy low
    a_no_accept_busy: assert property (@(posedge clk) disable iff (reset)
        $fell(req.rd || req.wr) |-> !$past(req.busy));

endmodule

// ==== design/readback_stage.sv ====
// Registers returned read beats and flags the last one of a burst
// start must coincide with read acceptance so the count is loaded
// before the first beat arrives
module readback_stage (
    input  logic                             clk,
    input  logic                             reset,

    input  logic                             start,
    input  logic [loader_pkg::BURST_W-1:0]   len,
    input  logic [loader_pkg::BEAT_W-1:0]    dout,
    input  logic                             dout_ready,

    output logic [loader_pkg::BEAT_W-1:0]    rd_data,
    output logic                             rd_valid,
    output logic                             rd_last,
    output logic                             burst_done
);

    // Beats still to come in the current burst
    logic [loader_pkg::BURST_W-1:0] remain;

    always_ff @(posedge clk) begin
        if (reset) begin
            remain   <= '0;
            rd_valid <= 1'b0;
            rd_last  <= 1'b0;
        end else begin
            rd_valid <= dout_ready;
            rd_last  <= dout_ready && (remain == 1);
            if (start) begin
                remain <= len;
            end else if (dout_ready) begin
                remain <= remain - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dout_ready) begin
            rd_data <= dout;
        end
    end

    // Releases rd_busy in the request stage
    assign burst_done = rd_last;

    // Memory must never return more beats than were asked for
    a_no_extra_beat: assert property (@(posedge clk) disable iff (reset)
        dout_ready |-> remain != '0);

endmodule

// ==== design/rom_loader.sv ====
// ROM download path with its burst memory and a readback port
// Host bytes go in while downloading is high; stored beats can be
// read back as bursts of 1 to 16 beats once downloading is low
// Wait for dwnld_busy low before each ioctl_wr, rd_busy low before rd_req
module rom_loader (
    input  logic                             clk,
    input  logic                             reset,

    // ROM download
    input  logic                             downloading,
    input  logic [loader_pkg::IOCTL_AW-1:0]  ioctl_addr,
    input  logic [7:0]                       ioctl_dout,
    input  logic                             ioctl_wr,
    output logic                             dwnld_busy,

    // Readback
    input  logic                             rd_req,
    input  logic [loader_pkg::MEM_AW-1:0]    rd_addr,
    input  logic [loader_pkg::BURST_W-1:0]   rd_len,
    output logic                             rd_busy,
    output logic [loader_pkg::BEAT_W-1:0]    rd_data,
    output logic                             rd_valid,
    output logic                             rd_last
);

    mem_req_if req ();

    logic [loader_pkg::BEAT_W-1:0] dout;
    logic                          dout_ready;
    logic                          burst_done;
    logic                          rd_start;

    // Read acceptance by the same rule the memory uses
    assign rd_start = req.rd && !req.busy;

    mem_request_stage i_request (
        .clk         (clk),
        .reset       (reset),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_dout  (ioctl_dout),
        .ioctl_wr    (ioctl_wr),
        .dwnld_busy  (dwnld_busy),
        .rd_req      (rd_req),
        .rd_addr     (rd_addr),
        .rd_len      (rd_len),
        .rd_busy     (rd_busy),
        .burst_done  (burst_done),
        .req         (req.host)
    );

    burst_memory i_memory (
        .clk        (clk),
        .reset      (reset),
        .req        (req.mem),
        .dout       (dout),
        .dout_ready (dout_ready)
    );

    readback_stage i_readback (
        .clk        (clk),
        .reset      (reset),
        .start      (rd_start),
        .len        (req.burstcnt),
        .dout       (dout),
        .dout_ready (dout_ready),
        .rd_data    (rd_data),
        .rd_valid   (rd_valid),
        .rd_last    (rd_last),
        .burst_done (burst_done)
    );

endmodule

// ==== bench/tb_rom_loader.sv ====
// Replays bench/loader_golden.txt against rom_loader
// Must run from the project root so the golden file is found
// Random idle gaps of up to 31 cycles push commands across refresh slots
module tb_rom_loader;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int    TIMEOUT = 200;
    localparam string GOLDEN  = "bench/loader_golden.txt";

    logic                             clk = 1'b0;
    logic                             reset;
    logic                             downloading;
    logic [loader_pkg::IOCTL_AW-1:0]  ioctl_addr;
    logic [7:0]                       ioctl_dout;
    logic                             ioctl_wr;
    logic                             dwnld_busy;
    logic                             rd_req;
    logic [loader_pkg::MEM_AW-1:0]    rd_addr;
    logic [loader_pkg::BURST_W-1:0]   rd_len;
    logic                             rd_busy;
    logic [loader_pkg::BEAT_W-1:0]    rd_data;
    logic                             rd_valid;
    logic                             rd_last;

    integer seed = 32'h5228_e046;
    int     errors = 0;
    int     tests = 0;
    int     failed = 0;
    int     errors_at_start = 0;
    string  test_name = "";

    // Beats the pending read must return in order
    logic [loader_pkg::BEAT_W-1:0] expect_q[$];

    rom_loader i_rom_loader (
        .clk         (clk),
        .reset       (reset),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_dout  (ioctl_dout),
        .ioctl_wr    (ioctl_wr),
        .dwnld_busy  (dwnld_busy),
        .rd_req      (rd_req),
        .rd_addr     (rd_addr),
        .rd_len      (rd_len),
        .rd_busy     (rd_busy),
        .rd_data     (rd_data),
        .rd_valid    (rd_valid),
        .rd_last     (rd_last)
    );

    always #4 clk = ~clk;

    task automatic idle_gap();
        int gap;
        gap = $unsigned($random(seed)) % 32;
        repeat (gap) @(posedge clk);
    endtask

    // Waits until both busy levels are low at a falling edge
    task automatic wait_idle();
        int n;
        n = 0;
        @(negedge clk);
        while ((dwnld_busy || rd_busy) && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        assert (!dwnld_busy && !rd_busy) else begin
            $display("Timeout at %0t: loader still busy after %0d cycles", $time, TIMEOUT);
            errors++;
        end
    endtask

    task automatic write_bytes(input logic [loader_pkg::IOCTL_AW-1:0] addr,
                               input logic [63:0] data, input int count, input logic dl);
        for (int k = 0; k < count; k++) begin
            wait_idle();
            idle_gap();
            @(posedge clk);
            downloading <= dl;
            ioctl_addr  <= addr + loader_pkg::IOCTL_AW'(k);
            ioctl_dout  <= data[8*k +: 8];
            ioctl_wr    <= 1'b1;
            @(posedge clk);
            ioctl_wr <= 1'b0;
            // A taken byte holds dwnld_busy high until the memory accepts it
            @(negedge clk);
            assert (dwnld_busy === dl) else begin
                $display("** Error at %0t: dwnld_busy expected %0d, got %0d",
                         $time, dl, dwnld_busy);
                errors++;
            end
        end
    endtask

    task automatic read_burst(input logic [7:0] addr, input int count);
        int n;
        n = 0;
        wait_idle();
        idle_gap();
        @(posedge clk);
        downloading <= 1'b0;
        rd_req      <= 1'b1;
        rd_addr     <= addr;
        rd_len      <= loader_pkg::BURST_W'(count - 1);
        @(posedge clk);
        rd_req <= 1'b0;
        @(negedge clk);
        while (!rd_valid && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        assert (rd_valid) else begin
            $display("Timeout at %0t: read of beat %h returned no data", $time, addr);
            errors++;
        end
        if (rd_valid) begin
            // Beats must come on consecutive cycles
            for (int k = 0; k < count; k++) begin
                if (k > 0) begin
                    @(negedge clk);
                end
                assert (rd_valid) else begin
                    $display("** Error at %0t: rd_valid expected 1, got 0 (beat %0d)",
                             $time, k);
                    errors++;
                end
                assert (rd_data === expect_q[k]) else begin
                    $display("** Error at %0t: rd_data expected %h, got %h",
                             $time, expect_q[k], rd_data);
                    errors++;
                end
                assert (rd_last === (k == count - 1)) else begin
                    $display("** Error at %0t: rd_last expected %0d, got %0d",
                             $time, k == count - 1, rd_last);
                    errors++;
                end
            end
            @(negedge clk);
            assert (!rd_valid) else begin
                $display("** Error at %0t: rd_valid expected 0, got 1 after the burst",
                         $time);
                errors++;
            end
        end
    endtask

    task automatic read_while_downloading(input logic [7:0] addr);
        int stray;
        stray = 0;
        wait_idle();
        @(posedge clk);
        downloading <= 1'b1;
        rd_req      <= 1'b1;
        rd_addr     <= addr;
        rd_len      <= '0;
        @(posedge clk);
        rd_req <= 1'b0;
        repeat (TIMEOUT) begin
            @(negedge clk);
            if (rd_valid || rd_busy) begin
                stray++;
            end
        end
        assert (stray == 0) else begin
            $display("Read request was taken while downloading (%0d active cycles)", stray);
            errors++;
        end
    endtask

    task automatic close_test();
        if (test_name != "") begin
            tests++;
            if (errors == errors_at_start) begin
                $display("test %s: ok", test_name);
            end else begin
                failed++;
                $display("test %s: failed, %0d errors", test_name, errors - errors_at_start);
            end
        end
    endtask

    initial begin
        int                              fd;
        string                           line;
        byte                             kind;
        logic [loader_pkg::IOCTL_AW-1:0] addr;
        logic [63:0]                     data;
        int                              count;
        int                              rep;
        int                              read_len;
        logic [7:0]                      read_addr;

        reset       = 1'b1;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        ioctl_wr    = 1'b0;
        rd_req      = 1'b0;
        rd_addr     = '0;
        rd_len      = '0;
        read_len    = 0;
        read_addr   = '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        fd = $fopen(GOLDEN, "r");
        assert (fd != 0) else begin
            $display("Could not open the golden file %s", GOLDEN);
            errors++;
        end
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                kind = line.getc(0);
                case (kind)
                    "T": begin
                        close_test();
                        test_name = line.substr(2, line.len() - 2);
                        errors_at_start = errors;
                    end
                    "W", "X": begin
                        void'($sscanf(line, "%c %h %h %d", kind, addr, data, count));
                        write_bytes(addr, data, count, kind == "W");
                    end
                    "R": begin
                        void'($sscanf(line, "%c %h %d", kind, read_addr, read_len));
                        expect_q.delete();
                    end
                    "E": begin
                        void'($sscanf(line, "%c %h %d", kind, data, rep));
                        repeat (rep) expect_q.push_back(data);
                        // Read runs once all its beats are known
                        if (expect_q.size() == read_len) begin
                            read_burst(read_addr, read_len);
                        end
                    end
                    "N": begin
                        void'($sscanf(line, "%c %h", kind, addr));
                        read_while_downloading(addr[7:0]);
                    end
                    default: begin
                        $display("Golden file has a line of unknown kind: %s", line);
                        errors++;
                    end
                endcase
            end
            $fclose(fd);
        end
        close_test();

        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
design/loader_pkg.sv
design/mem_req_if.sv
design/mem_request_stage.sv
design/burst_memory.sv
design/readback_stage.sv
design/rom_loader.sv
bench/tb_rom_loader.sv

// ==== run.sh ====
#!/bin/sh
# Builds the loader testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module tb_rom_loader -f sources.f

# The simulation result is taken from the log, not from the exit status
./obj_dir/Vtb_rom_loader > sim.log 2>&1 || true
cat sim.log

if grep -q '^>>> PASS$' sim.log; then
    exit 0
else
    exit 1
fi

// ==== bench/loader_golden.txt ====
# T name | W byte_addr data count | X same with downloading low | N beat
# R beat count, then E beat repeat lines; byte k of data goes to byte_addr+k
T beat_assembly
W 0000000 8877665544332211 8
W 0000008 f0debc9a78563412 8
W 0000010 0123456789abcdef 8
R 00 1
E 8877665544332211 1
R 01 1
E f0debc9a78563412 1
R 02 1
E 0123456789abcdef 1
T wrap_burst
W 00007f8 a5a5a5a5a5a5a5a5 8
R fa 16
E 0000000000000000 5
E a5a5a5a5a5a5a5a5 1
E 8877665544332211 1
E f0debc9a78563412 1
E 0123456789abcdef 1
E 0000000000000000 7
T write_ignored_when_idle
X 0000000 ffffffffffffffff 8
R 00 1
E 8877665544332211 1
T read_ignored_while_downloading
N 10
T address_alias
W 3fff813 000000000000005a 1
R 02 1
E 012345675aabcdef 1
T refresh_straddle
W 0000200 1122334455667788 8
W 0000208 99aabbccddeeff00 3
R 40 2
E 1122334455667788 1
E 0000000000eeff00 1
